// ==== common/list_pkg.sv ====
package list_pkg;

  // List sizing
  localparam int ENTRIES_N = 4;
  localparam int IDS_N = 8;

  // Field widths
  localparam int ID_W = 3;
  localparam int KEY_W = 8;
  localparam int VOL_W = 8;

  // Product id, also the table address
  typedef logic [ID_W-1:0] id_t;
  typedef logic [KEY_W-1:0] key_t;
  // Volume and command size share one width
  typedef logic [VOL_W-1:0] vol_t;

  // Update commands
  typedef enum logic [1:0] {
    CMD_NOP = 2'd0,
    CMD_ADD = 2'd1,
    CMD_DEL = 2'd2,
    CMD_CLR = 2'd3
  } cmd_t;

  // Count of live entries, 0 up to ENTRIES_N
  typedef logic [$clog2(ENTRIES_N + 1)-1:0] lsize_t;

  // One bit per list entry
  typedef logic [ENTRIES_N-1:0] sel_t;

  // One table word per product id
  // All zeros is the empty list
  typedef struct packed {
    sel_t                 vld;
    key_t [ENTRIES_N-1:0] key;
    vol_t [ENTRIES_N-1:0] vol;
    lsize_t               size;
  } state_t;

endpackage

// ==== update_pipe/list_match.sv ====
module list_match (
    input  wire list_pkg::key_t   i_key
  , input  wire list_pkg::state_t i_state
  , output logic                  o_hit
  , output logic                  o_full
  , output list_pkg::sel_t        o_hit_sel
  , output list_pkg::sel_t        o_free_sel
);

  import list_pkg::*;

  // Key compare against every live entry
  always_comb begin
    for (int i = 0; i < ENTRIES_N; i++) begin
      o_hit_sel[i] = i_state.vld[i] && (i_state.key[i] == i_key);
    end
  end

  assign o_hit = |o_hit_sel;

  // Lowest clear bit of the valid mask
  // zero when the list is full
  assign o_free_sel = ~i_state.vld & (i_state.vld + sel_t'(1));
  assign o_full = &i_state.vld;

  // Exec never inserts a key twice, so one entry at most can match
  always_comb begin
    a_hit_onehot: assert ($onehot0(o_hit_sel))
      else $error("list_match: key held in more than one entry");
  end

endmodule

// ==== update_pipe/list_exec.sv ====
module list_exec (
    input  wire list_pkg::cmd_t   i_cmd
  , input  wire list_pkg::key_t   i_key
  , input  wire list_pkg::vol_t   i_size
  , input  wire logic             i_hit
  , input  wire logic             i_full
  , input  wire list_pkg::sel_t   i_hit_sel
  , input  wire list_pkg::sel_t   i_free_sel
  , input  wire list_pkg::state_t i_state
  , output list_pkg::state_t      o_state
  , output logic                  o_notify
  , output list_pkg::key_t        o_notify_key
  , output list_pkg::vol_t        o_notify_vol
);

  import list_pkg::*;

  vol_t           hit_vol;
  logic [VOL_W:0] vol_sum;
  vol_t           vol_sat;

  // Volume of the matching entry
  always_comb begin
    hit_vol = '0;
    for (int i = 0; i < ENTRIES_N; i++) begin
      if (i_hit_sel[i]) begin
        hit_vol = hit_vol | i_state.vol[i];
      end
    end
  end

  // One carry bit, clamp to all ones on overflow
  assign vol_sum = {1'b0, hit_vol} + {1'b0, i_size};
  assign vol_sat = vol_sum[VOL_W] ? '1 : vol_sum[VOL_W-1:0];

  always_comb begin
    o_state = i_state;
    o_notify = 1'b0;
    o_notify_vol = '0;
    case (i_cmd)
      CMD_ADD: begin
        if (i_hit) begin
          // Accumulate on the matching entry
          for (int i = 0; i < ENTRIES_N; i++) begin
            if (i_hit_sel[i]) begin
              o_state.vol[i] = vol_sat;
            end
          end
          o_notify = 1'b1;
          o_notify_vol = vol_sat;
        end else if (!i_full) begin
          // New key takes the lowest free slot
          for (int i = 0; i < ENTRIES_N; i++) begin
            if (i_free_sel[i]) begin
              o_state.vld[i] = 1'b1;
              o_state.key[i] = i_key;
              o_state.vol[i] = i_size;
            end
          end
          o_state.size = i_state.size + 1'b1;
          o_notify = 1'b1;
          o_notify_vol = i_size;
        end
      end
      CMD_DEL: begin
        // Removal reported as volume 0
        if (i_hit) begin
          o_state.vld = i_state.vld & ~i_hit_sel;
          o_state.size = i_state.size - 1'b1;
          o_notify = 1'b1;
        end
      end
      CMD_CLR: begin
        o_state.vld = '0;
        o_state.size = '0;
      end
      default: begin
      end
    endcase
  end

  assign o_notify_key = i_key;

  // A consistent list stays consistent through every command
  always_comb begin
    if (i_state.size == lsize_t'($countones(i_state.vld))) begin
      a_size_mask: assert (o_state.size <= lsize_t'(ENTRIES_N) &&
                           o_state.size == lsize_t'($countones(o_state.vld)))
        else $error("list_exec: list size out of step with valid mask");
    end
  end

endmodule

// ==== update_pipe/update_pipe.sv ====
module update_pipe (
    input  wire logic             i_clk
  , input  wire logic             i_rst
  , input  wire logic             i_init
  // Command strobe
  , input  wire logic             i_upd_vld
  , input  wire list_pkg::id_t    i_upd_id
  , input  wire list_pkg::cmd_t   i_upd_cmd
  , input  wire list_pkg::key_t   i_upd_key
  , input  wire list_pkg::vol_t   i_upd_size
  // State table
  , input  wire list_pkg::state_t i_state_rdata
  , output logic                  o_state_ren
  , output list_pkg::id_t         o_state_raddr
  , output logic                  o_state_wen
  , output list_pkg::id_t         o_state_waddr
  , output list_pkg::state_t      o_state_wdata
  // Notify bus
  , output logic                  o_notify_vld
  , output list_pkg::id_t         o_notify_id
  , output list_pkg::key_t        o_notify_key
  , output list_pkg::vol_t        o_notify_vol
);

  import list_pkg::*;

  // Stage enables, also the next valid bits
  logic   s1_en, s2_en, s3_en, s4_en, wb_en, nfy_en;
  // Valid bits
  logic   s1_vld_r, s2_vld_r, s3_vld_r, s4_vld_r, wb_vld_r, nfy_vld_r;
  // Command payload per stage
  id_t    s1_id_r, s2_id_r, s3_id_r, s4_id_r;
  cmd_t   s1_cmd_r, s2_cmd_r, s3_cmd_r, s4_cmd_r;
  key_t   s1_key_r, s2_key_r, s3_key_r, s4_key_r;
  vol_t   s1_size_r, s2_size_r, s3_size_r, s4_size_r;
  // Write-back seen in S1, kept for S2
  logic   s1_wb_hit;
  logic   s2_rec_vld_r;
  state_t s2_rec_state_r;
  // Forwarded state per stage
  logic   s2_wb_hit, s3_s4_hit, s3_wb_hit;
  state_t s2_state, s3_state_r, s3_state, s4_state_r;
  // Compare results
  logic   s3_hit, s3_full, s4_hit_r, s4_full_r;
  sel_t   s3_hit_sel, s3_free_sel, s4_hit_sel_r, s4_free_sel_r;
  // Execute results
  state_t exe_state;
  logic   exe_notify;
  key_t   exe_key;
  vol_t   exe_vol;
  // Write-back and notify registers
  id_t    wb_id_r, nfy_id_r;
  state_t wb_state_r;
  key_t   nfy_key_r;
  vol_t   nfy_vol_r;

  // Newest matching producer wins, else the stage's own state
  function automatic state_t fwd_pick(input logic hit_new, input state_t st_new,
                                      input logic hit_old, input state_t st_old,
                                      input state_t st_base);
    if (hit_new) begin
      return st_new;
    end
    if (hit_old) begin
      return st_old;
    end
    return st_base;
  endfunction

  // Init kills every stage
  assign s1_en = i_upd_vld & ~i_init;
  assign s2_en = s1_vld_r & ~i_init;
  assign s3_en = s2_vld_r & ~i_init;
  assign s4_en = s3_vld_r & ~i_init;
  assign wb_en = s4_vld_r & ~i_init;
  assign nfy_en = wb_en & exe_notify;

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      s1_vld_r <= 1'b0;
      s2_vld_r <= 1'b0;
      s3_vld_r <= 1'b0;
      s4_vld_r <= 1'b0;
      wb_vld_r <= 1'b0;
      nfy_vld_r <= 1'b0;
    end else begin
      s1_vld_r <= s1_en;
      s2_vld_r <= s2_en;
      s3_vld_r <= s3_en;
      s4_vld_r <= s4_en;
      wb_vld_r <= wb_en;
      nfy_vld_r <= nfy_en;
    end
  end

  // S1 table read, killed when write-back hits the same id this cycle
  assign s1_wb_hit = wb_vld_r & (wb_id_r == s1_id_r);
  assign o_state_ren = s1_vld_r & ~s1_wb_hit;
  assign o_state_raddr = s1_id_r;

  // S2 covers producers 3 and 4 commands ahead
  assign s2_wb_hit = wb_vld_r & (wb_id_r == s2_id_r);
  assign s2_state = fwd_pick(s2_wb_hit, wb_state_r, s2_rec_vld_r, s2_rec_state_r,
                             i_state_rdata);

  // S3 covers producers 1 and 2 ahead
  assign s3_s4_hit = s4_vld_r & (s4_id_r == s3_id_r);
  assign s3_wb_hit = wb_vld_r & (wb_id_r == s3_id_r);
  assign s3_state = fwd_pick(s3_s4_hit, exe_state, s3_wb_hit, wb_state_r, s3_state_r);

  // payload registers
  always_ff @(posedge i_clk) begin
    if (s1_en) begin
      s1_id_r <= i_upd_id;
      s1_cmd_r <= i_upd_cmd;
      s1_key_r <= i_upd_key;
      s1_size_r <= i_upd_size;
    end
    if (s2_en) begin
      s2_id_r <= s1_id_r;
      s2_cmd_r <= s1_cmd_r;
      s2_key_r <= s1_key_r;
      s2_size_r <= s1_size_r;
      s2_rec_vld_r <= s1_wb_hit;
      s2_rec_state_r <= wb_state_r;
    end
    if (s3_en) begin
      s3_id_r <= s2_id_r;
      s3_cmd_r <= s2_cmd_r;
      s3_key_r <= s2_key_r;
      s3_size_r <= s2_size_r;
      s3_state_r <= s2_state;
    end
    if (s4_en) begin
      s4_id_r <= s3_id_r;
      s4_cmd_r <= s3_cmd_r;
      s4_key_r <= s3_key_r;
      s4_size_r <= s3_size_r;
      s4_state_r <= s3_state;
      s4_hit_r <= s3_hit;
      s4_full_r <= s3_full;
      s4_hit_sel_r <= s3_hit_sel;
      s4_free_sel_r <= s3_free_sel;
    end
    if (wb_en) begin
      wb_id_r <= s4_id_r;
      wb_state_r <= exe_state;
    end
    if (nfy_en) begin
      nfy_id_r <= s4_id_r;
      nfy_key_r <= exe_key;
      nfy_vol_r <= exe_vol;
    end
  end

  list_match u_list_match (
      .i_key      (s3_key_r)
    , .i_state    (s3_state)
    , .o_hit      (s3_hit)
    , .o_full     (s3_full)
    , .o_hit_sel  (s3_hit_sel)
    , .o_free_sel (s3_free_sel)
  );

  list_exec u_list_exec (
      .i_cmd        (s4_cmd_r)
    , .i_key        (s4_key_r)
    , .i_size       (s4_size_r)
    , .i_hit        (s4_hit_r)
    , .i_full       (s4_full_r)
    , .i_hit_sel    (s4_hit_sel_r)
    , .i_free_sel   (s4_free_sel_r)
    , .i_state      (s4_state_r)
    , .o_state      (exe_state)
    , .o_notify     (exe_notify)
    , .o_notify_key (exe_key)
    , .o_notify_vol (exe_vol)
  );

  assign o_state_wen = wb_vld_r;
  assign o_state_waddr = wb_id_r;
  assign o_state_wdata = wb_state_r;

  assign o_notify_vld = nfy_vld_r;
  assign o_notify_id = nfy_id_r;
  assign o_notify_key = nfy_key_r;
  assign o_notify_vol = nfy_vol_r;

  // Init kill is only for the sweep after reset
  // A later kill would drop write-backs and leave forwarding stale
  a_init_once: assert property (@(posedge i_clk) disable iff (i_rst)
    !i_init |=> !i_init)
    else $error("update_pipe: init rose again with commands in flight");

endmodule

// ==== src/state_table.sv ====
module state_table (
    input  wire logic             i_clk
  , input  wire logic             i_rst
  // Read port, data one cycle after the strobe
  , input  wire logic             i_ren
  , input  wire list_pkg::id_t    i_raddr
  // Write port
  , input  wire logic             i_wen
  , input  wire list_pkg::id_t    i_waddr
  , input  wire list_pkg::state_t i_wdata
  , output list_pkg::state_t      o_rdata
  // High during the clearing sweep
  , output logic                  o_init
);

  import list_pkg::*;

  state_t mem [IDS_N];
  state_t rdata_r;
  logic   init_r;
  id_t    sweep_r;

  // Sweep control, one address per cycle
  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      init_r <= 1'b1;
      sweep_r <= '0;
    end else if (init_r) begin
      sweep_r <= sweep_r + 1'b1;
      // Last address written, table ready
      if (sweep_r == id_t'(IDS_N - 1)) begin
        init_r <= 1'b0;
      end
    end
  end

  // Sweep owns the write port while it runs
  always_ff @(posedge i_clk) begin
    if (init_r) begin
      mem[sweep_r] <= '0;
    end else if (i_wen) begin
      mem[i_waddr] <= i_wdata;
    end
  end

  // Same-address write in this cycle is not seen here
  always_ff @(posedge i_clk) begin
    if (i_ren) begin
      rdata_r <= mem[i_raddr];
    end
  end

  assign o_rdata = rdata_r;
  assign o_init = init_r;

  // Pipeline stays quiet until the sweep is over
  a_quiet_in_init: assert property (@(posedge i_clk) disable iff (i_rst)
    o_init |-> !i_ren && !i_wen)
    else $error("state_table: access during init sweep");

endmodule

// ==== src/list_engine_top.sv ====
module list_engine_top (
    input  wire logic            i_clk
  , input  wire logic            i_rst
  // Command strobe
  , input  wire logic            i_upd_vld
  , input  wire list_pkg::id_t   i_upd_id
  , input  wire list_pkg::cmd_t  i_upd_cmd
  , input  wire list_pkg::key_t  i_upd_key
  , input  wire list_pkg::vol_t  i_upd_size
  // Notify bus
  , output logic                 o_notify_vld
  , output list_pkg::id_t        o_notify_id
  , output list_pkg::key_t       o_notify_key
  , output list_pkg::vol_t       o_notify_vol
  // High while the table clears after reset
  , output logic                 o_busy
);

  import list_pkg::*;

  // Table read port
  logic   state_ren;
  id_t    state_raddr;
  state_t state_rdata;
  // Table write port, fed by the write-back register
  logic   state_wen;
  id_t    state_waddr;
  state_t state_wdata;

  // Init level of the table is the busy flag and the pipeline kill
  state_table u_state_table (
      .i_clk   (i_clk)
    , .i_rst   (i_rst)
    , .i_ren   (state_ren)
    , .i_raddr (state_raddr)
    , .i_wen   (state_wen)
    , .i_waddr (state_waddr)
    , .i_wdata (state_wdata)
    , .o_rdata (state_rdata)
    , .o_init  (o_busy)
  );

  update_pipe u_update_pipe (
      .i_clk          (i_clk)
    , .i_rst          (i_rst)
    , .i_init         (o_busy)
    , .i_upd_vld      (i_upd_vld)
    , .i_upd_id       (i_upd_id)
    , .i_upd_cmd      (i_upd_cmd)
    , .i_upd_key      (i_upd_key)
    , .i_upd_size     (i_upd_size)
    , .i_state_rdata  (state_rdata)
    , .o_state_ren    (state_ren)
    , .o_state_raddr  (state_raddr)
    , .o_state_wen    (state_wen)
    , .o_state_waddr  (state_waddr)
    , .o_state_wdata  (state_wdata)
    , .o_notify_vld   (o_notify_vld)
    , .o_notify_id    (o_notify_id)
    , .o_notify_key   (o_notify_key)
    , .o_notify_vol   (o_notify_vol)
  );

endmodule

// ==== testbench/tb_list_engine.sv ====
module tb_list_engine;

  import list_pkg::*;

  // Expected notify beat with the cycle it must show up in
  typedef struct packed {
    id_t         id;
    key_t        key;
    vol_t        vol;
    logic [31:0] cyc;
  } beat_t;

  logic i_clk = 1'b0;
  logic i_rst;
  logic i_upd_vld;
  id_t  i_upd_id;
  cmd_t i_upd_cmd;
  key_t i_upd_key;
  vol_t i_upd_size;
  logic o_notify_vld;
  id_t  o_notify_id;
  key_t o_notify_key;
  vol_t o_notify_vol;
  logic o_busy;

  // Model lists, one per product id
  logic  m_vld [IDS_N][ENTRIES_N];
  key_t  m_key [IDS_N][ENTRIES_N];
  vol_t  m_vol [IDS_N][ENTRIES_N];
  beat_t exp_q [$];
  beat_t got_exp;
  int    cyc = 0;
  int    n_checks = 0;
  int    n_errors = 0;
  int    seed = 80423;

  list_engine_top UUT (
      .i_clk        (i_clk)
    , .i_rst        (i_rst)
    , .i_upd_vld    (i_upd_vld)
    , .i_upd_id     (i_upd_id)
    , .i_upd_cmd    (i_upd_cmd)
    , .i_upd_key    (i_upd_key)
    , .i_upd_size   (i_upd_size)
    , .o_notify_vld (o_notify_vld)
    , .o_notify_id  (o_notify_id)
    , .o_notify_key (o_notify_key)
    , .o_notify_vol (o_notify_vol)
    , .o_busy       (o_busy)
  );

  always #2 i_clk = ~i_clk;

  always @(posedge i_clk) cyc <= cyc + 1;

  // Applies one command to the model, returns 1 when a notify is due
  function automatic logic model_apply(input cmd_t cmd, input id_t id, input key_t key,
                                       input vol_t size, output vol_t vol);
    int             hit;
    int             free;
    logic [VOL_W:0] sum;
    hit = -1;
    free = -1;
    vol = '0;
    for (int i = 0; i < ENTRIES_N; i++) begin
      if (m_vld[id][i] && m_key[id][i] == key) begin
        hit = i;
      end
      if (!m_vld[id][i] && free < 0) begin
        free = i;
      end
    end
    case (cmd)
      CMD_ADD: begin
        if (hit >= 0) begin
          // Clamp at the largest volume
          sum = {1'b0, m_vol[id][hit]} + {1'b0, size};
          vol = sum[VOL_W] ? '1 : sum[VOL_W-1:0];
          m_vol[id][hit] = vol;
          return 1'b1;
        end else if (free >= 0) begin
          m_vld[id][free] = 1'b1;
          m_key[id][free] = key;
          m_vol[id][free] = size;
          vol = size;
          return 1'b1;
        end
      end
      CMD_DEL: begin
        if (hit >= 0) begin
          m_vld[id][hit] = 1'b0;
          return 1'b1;
        end
      end
      CMD_CLR: begin
        for (int i = 0; i < ENTRIES_N; i++) begin
          m_vld[id][i] = 1'b0;
        end
      end
      default: begin
      end
    endcase
    return 1'b0;
  endfunction

  task automatic check_id(input string name, input id_t got, input id_t exp);
    n_checks++;
    if (got !== exp) begin
      n_errors++;
      $display("ERR %s got 0x%0h expected 0x%0h", name, got, exp);
    end
  endtask

  task automatic check_key(input string name, input key_t got, input key_t exp);
    n_checks++;
    if (got !== exp) begin
      n_errors++;
      $display("ERR %s got 0x%0h expected 0x%0h", name, got, exp);
    end
  endtask

  task automatic check_vol(input string name, input vol_t got, input vol_t exp);
    n_checks++;
    if (got !== exp) begin
      n_errors++;
      $display("ERR %s got 0x%0h expected 0x%0h", name, got, exp);
    end
  endtask

  // Notify bus is stable at the falling edge
  always @(negedge i_clk) begin
    if (!i_rst && o_notify_vld === 1'b1) begin
      if (exp_q.size() == 0) begin
        n_errors++;
        $display("notify beat for id %0d at cycle %0d was not expected", o_notify_id, cyc);
      end else begin
        got_exp = exp_q.pop_front();
        check_id("o_notify_id", o_notify_id, got_exp.id);
        check_key("o_notify_key", o_notify_key, got_exp.key);
        check_vol("o_notify_vol", o_notify_vol, got_exp.vol);
        n_checks++;
        if (cyc != int'(got_exp.cyc)) begin
          n_errors++;
          $display("notify beat came at cycle %0d instead of cycle %0d", cyc, got_exp.cyc);
        end
      end
    end
  end

  // One command for one cycle, sampled at the next rising edge
  task automatic send(input cmd_t cmd, input id_t id, input key_t key, input vol_t size);
    vol_t  vol;
    beat_t b;
    i_upd_vld = 1'b1;
    i_upd_cmd = cmd;
    i_upd_id = id;
    i_upd_key = key;
    i_upd_size = size;
    if (model_apply(cmd, id, key, size, vol)) begin
      b.id = id;
      b.key = key;
      b.vol = vol;
      // Sampled at the next edge, beat seen after four more
      b.cyc = 32'(cyc + 5);
      exp_q.push_back(b);
    end
    @(posedge i_clk);
    #1;
    i_upd_vld = 1'b0;
  endtask

  task automatic idle(input int n);
    repeat (n) begin
      @(posedge i_clk);
      #1;
    end
  endtask

  // Waits out the pipeline so missing and stray beats both show
  task automatic drain();
    int t;
    t = 0;
    while ((exp_q.size() != 0 || t < 6) && t < 200) begin
      @(posedge i_clk);
      #1;
      t++;
    end
    if (exp_q.size() != 0) begin
      n_errors++;
      $display("%0d expected notify beats never arrived", exp_q.size());
      exp_q.delete();
    end
  endtask

  task automatic report(input int num, input string name, input int err_start);
    $display("test %0d %-12s %s", num, name, (n_errors == err_start) ? "ok" : "FAILED");
  endtask

  initial begin
    int   t;
    int   e0;
    int   r;
    cmd_t cmd;
    i_rst = 1'b1;
    i_upd_vld = 1'b0;
    i_upd_id = '0;
    i_upd_cmd = CMD_NOP;
    i_upd_key = '0;
    i_upd_size = '0;
    for (int i = 0; i < IDS_N; i++) begin
      for (int j = 0; j < ENTRIES_N; j++) begin
        m_vld[i][j] = 1'b0;
        m_key[i][j] = '0;
        m_vol[i][j] = '0;
      end
    end
    repeat (4) @(posedge i_clk);
    #1;
    i_rst = 1'b0;
    // Command held through the sweep, the DUT must drop it
    i_upd_vld = 1'b1;
    i_upd_cmd = CMD_ADD;
    i_upd_id = 3'd2;
    i_upd_key = 8'h33;
    i_upd_size = 8'h44;
    // Table sweep must end before commands count
    t = 0;
    while (o_busy !== 1'b0 && t < 50) begin
      @(posedge i_clk);
      #1;
      t++;
    end
    i_upd_vld = 1'b0;
    if (o_busy !== 1'b0) begin
      $display("table clearing never finished after reset");
      $display("Simulation failed");
      $finish;
    end else begin
      // One sweep step per product id
      e0 = n_errors;
      n_checks++;
      if (t != IDS_N) begin
        n_errors++;
        $display("o_busy stayed high for %0d cycles instead of %0d", t, IDS_N);
      end
      drain();
      report(0, "init", e0);
      // Fill id 0, fifth key finds the list full
      e0 = n_errors;
      for (int k = 1; k <= 5; k++) begin
        send(CMD_ADD, 3'd0, key_t'(k), vol_t'(k * 10));
      end
      drain();
      report(1, "fill", e0);
      // Accumulate up to saturation
      e0 = n_errors;
      for (int k = 0; k < 4; k++) begin
        send(CMD_ADD, 3'd1, 8'h09, 8'd100);
      end
      drain();
      report(2, "accumulate", e0);
      // Delete present and absent keys, then reuse the freed slot
      e0 = n_errors;
      send(CMD_DEL, 3'd0, 8'd2, 8'd0);
      send(CMD_DEL, 3'd0, 8'd7, 8'd0);
      send(CMD_ADD, 3'd0, 8'd6, 8'd5);
      drain();
      report(3, "delete", e0);
      // Old key comes back with its bare size
      e0 = n_errors;
      send(CMD_CLR, 3'd0, 8'd0, 8'd0);
      send(CMD_ADD, 3'd0, 8'd1, 8'd3);
      drain();
      report(4, "clear", e0);
      // Gaps 0 to 4 reach every forwarding distance
      e0 = n_errors;
      for (int g = 0; g <= 4; g++) begin
        send(CMD_ADD, 3'd5, 8'd7, vol_t'(g + 1));
        idle(g);
        send(CMD_ADD, 3'd5, 8'd7, 8'd3);
        send(CMD_DEL, 3'd5, 8'd7, 8'd0);
        idle(g);
        send(CMD_ADD, 3'd5, 8'd8, 8'd2);
      end
      drain();
      report(5, "forwarding", e0);
      // Random mix, small key range so hits are common
      e0 = n_errors;
      for (int n = 0; n < 300; n++) begin
        r = {$random(seed)} % 8;
        cmd = (r < 4) ? CMD_ADD : (r < 6) ? CMD_DEL : (r == 6) ? CMD_CLR : CMD_NOP;
        send(cmd, id_t'($random(seed)), key_t'({$random(seed)} % 6), vol_t'($random(seed)));
        if ({$random(seed)} % 4 == 0) begin
          idle(1);
        end
      end
      drain();
      report(6, "random", e0);
      $display("checks %0d errors %0d", n_checks, n_errors);
      if (n_errors == 0) begin
        $display("Simulation completed successfully");
      end else begin
        $display("Simulation failed");
      end
      $finish;
    end
  end

endmodule

// ==== flist.f ====
common/list_pkg.sv
update_pipe/list_match.sv
update_pipe/list_exec.sv
update_pipe/update_pipe.sv
src/state_table.sv
src/list_engine_top.sv
testbench/tb_list_engine.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       ?= tb_list_engine
BUILD_DIR ?= obj_dir
FLIST     ?= flist.f
PASS_MSG  := Simulation completed successfully

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "Variables: VERILATOR VFLAGS TOP BUILD_DIR FLIST"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD_DIR) -o $(TOP)
	@out="$$(./$(BUILD_DIR)/$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
